//--- design/corr_cmd_pkg.sv
`default_nettype none

package corr_cmd_pkg;

	// low nibble of a command byte; the high nibble is the argument.
	typedef enum logic [3:0] {
		CLEAR          = 4'd0,
		SET_LINE       = 4'd1,
		SELECT_FIELD   = 4'd3,
		SET_VALUE      = 4'd8,
		ENABLE_CAPTURE = 4'd13
	} cmd_opcode_e;

	localparam int NIBBLE_W = 4;

	// the first nibble of a load gives the count of nibbles that follow.
	localparam int WORD_IDX_W = 3;
	localparam int MAX_NIBBLES = 4;
	localparam int WORD_W = MAX_NIBBLES * NIBBLE_W;

	// flag positions in the argument nibble of ENABLE_CAPTURE.
	localparam int CAP_INTEGRATING_BIT = 0;

endpackage

`default_nettype wire

//--- design/corr_cfg_pkg.sv
`default_nettype none

package corr_cfg_pkg;

	localparam int NUM_LINES = 4;
	localparam int LINE_W = 2;

	// window length, window counter and both hit counters share this width.
	localparam int WIN_W = 16;

	// cross lag runs from 0 to LAG_DEPTH - 1 cycles.
	localparam int LAG_W = 4;
	localparam int LAG_DEPTH = 1 << LAG_W;

	typedef enum logic [1:0] {
		FIELD_WINDOW = 2'd0,
		FIELD_LAG    = 2'd1
	} cfg_field_e;

	// restored by reset and by a CLEAR of the settings group.
	localparam logic [WIN_W-1:0] WINDOW_RESET = 16'd1023;
	localparam logic [LAG_W-1:0] LAG_RESET = 4'd0;

endpackage

`default_nettype wire

//--- design/cfg_bus_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cfg_bus_if
	import corr_cfg_pkg::*;
();

	logic              wr;          // one-cycle write strobe.
	logic              clear;       // one-cycle strobe that restores every channel.
	logic [LINE_W-1:0] line;
	cfg_field_e        field;
	logic [WIN_W-1:0]  value;
	logic              integrating; // channels run windows while this level is high.

	modport decoder (
		output wr,
		output clear,
		output line,
		output field,
		output value,
		output integrating
	);

	modport channel (
		input wr,
		input clear,
		input line,
		input field,
		input value,
		input integrating
	);

endinterface

`default_nettype wire

//--- design/line_result_if.sv
`timescale 1ns/100ps
`default_nettype none

interface line_result_if
	import corr_cfg_pkg::*;
();

	logic             valid;       // held until the cycle after taken.
	logic [WIN_W-1:0] auto_count;
	logic [WIN_W-1:0] cross_count;
	logic             taken;       // one-cycle strobe from the collector.

	modport producer (
		output valid,
		output auto_count,
		output cross_count,
		input  taken
	);

	modport consumer (
		input  valid,
		input  auto_count,
		input  cross_count,
		output taken
	);

endinterface

`default_nettype wire

//--- design/cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder
	import corr_cmd_pkg::*;
	import corr_cfg_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       cmd_req,
	input  logic [7:0] cmd_byte,
	output logic       cmd_ack,
	cfg_bus_if.decoder cfg
);

	typedef enum logic [1:0] {
		IDLE,
		ACK,
		WAIT_LOW
	} hs_state_e;

	hs_state_e             state;
	logic [7:0]            byte_q;
	cmd_opcode_e           opcode;
	cmd_opcode_e           group;
	logic [NIBBLE_W-1:0]   arg;
	logic [LINE_W-1:0]     current_line;
	cfg_field_e            field;
	logic [WORD_IDX_W-1:0] word_len;
	logic [WORD_IDX_W-1:0] word_idx;
	logic [WORD_W-1:0]     word_acc;
	logic [WORD_W-1:0]     word_next;
	logic                  word_last;
	logic                  integrating;
	logic                  wr;
	logic                  clear;

	// ACK is the single cycle in which the latched byte is executed.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_req) begin
						state <= ACK;
					end
				end
				ACK: begin
					state <= WAIT_LOW;
				end
				WAIT_LOW: begin
					if (!cmd_req) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign cmd_ack = (state != IDLE);

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_req) begin
			byte_q <= cmd_byte; // the host may change the byte once ack is seen.
		end
	end

	assign opcode = cmd_opcode_e'(byte_q[3:0]);
	assign arg = byte_q[7:4];
	assign group = cmd_opcode_e'(arg);

	always_comb begin
		word_next = word_acc;
		word_next[word_idx*NIBBLE_W +: NIBBLE_W] = arg; // least significant nibble first.
	end

	assign word_last = (word_idx + 1'b1 == word_len);

	always_ff @(posedge clk) begin
		if (state == ACK && (opcode == SET_LINE || opcode == SET_VALUE)) begin
			if (word_len == '0) begin
				word_acc <= '0;
			end else if (word_idx < word_len) begin
				word_acc <= word_next;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			current_line <= '0;
			field <= FIELD_WINDOW;
			word_len <= '0;
			word_idx <= '0;
			integrating <= 1'b0;
			wr <= 1'b0;
			clear <= 1'b0;
		end else begin
			wr <= 1'b0;
			clear <= 1'b0;
			if (state == ACK) begin
				case (opcode)
					CLEAR: begin
						word_len <= '0;
						word_idx <= '0;
						case (group)
							SET_LINE:       current_line <= '0;
							SELECT_FIELD:   field <= FIELD_WINDOW;
							SET_VALUE:      clear <= 1'b1;
							ENABLE_CAPTURE: integrating <= 1'b0;
							default:        ;
						endcase
					end
					SELECT_FIELD: begin
						field <= (arg[1:0] == FIELD_LAG) ? FIELD_LAG : FIELD_WINDOW;
					end
					ENABLE_CAPTURE: begin
						integrating <= arg[CAP_INTEGRATING_BIT];
					end
					SET_LINE, SET_VALUE: begin
						if (word_len == '0) begin
							word_len <= (arg > MAX_NIBBLES) ?
								WORD_IDX_W'(MAX_NIBBLES) : arg[WORD_IDX_W-1:0];
							word_idx <= '0;
							if (opcode == SET_LINE) begin
								current_line <= '0;
							end
						end else if (word_idx < word_len) begin
							word_idx <= word_idx + 1'b1;
							if (opcode == SET_LINE) begin
								current_line <= word_next[LINE_W-1:0];
							end else if (word_last) begin
								wr <= 1'b1; // value is complete in word_acc next cycle.
							end
						end else begin
							word_len <= '0; // a byte past the length ends the load.
						end
					end
					default: ;
				endcase
			end
		end
	end

	assign cfg.wr = wr;
	assign cfg.clear = clear;
	assign cfg.line = current_line;
	assign cfg.field = field;
	assign cfg.value = word_acc;
	assign cfg.integrating = integrating;

endmodule

`default_nettype wire

//--- design/line_correlator.sv
`timescale 1ns/100ps
`default_nettype none

module line_correlator
	import corr_cfg_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [LINE_W-1:0] index,
	input  logic              pulse,
	input  logic              ref_pulse,
	cfg_bus_if.channel        cfg,
	line_result_if.producer   res
);

	logic [WIN_W-1:0]     window_len;
	logic [LAG_W-1:0]     lag;
	logic [LAG_DEPTH-2:0] ref_dly;
	logic [LAG_DEPTH-1:0] ref_taps;
	logic                 ref_lagged;
	logic                 active;
	logic                 start;
	logic                 window_done;
	logic [WIN_W-1:0]     win_cnt;
	logic [WIN_W-1:0]     auto_cnt;
	logic [WIN_W-1:0]     cross_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			window_len <= WINDOW_RESET;
			lag <= LAG_RESET;
		end else if (cfg.clear) begin
			window_len <= WINDOW_RESET;
			lag <= LAG_RESET;
		end else if (cfg.wr && cfg.line == index) begin
			case (cfg.field)
				FIELD_WINDOW: window_len <= cfg.value;
				FIELD_LAG:    lag <= cfg.value[LAG_W-1:0];
				default:      ;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ref_dly <= '0;
		end else begin
			ref_dly <= {ref_dly[LAG_DEPTH-3:0], ref_pulse};
		end
	end

	assign ref_taps = {ref_dly, ref_pulse}; // tap k is the reference k cycles ago.
	assign ref_lagged = ref_taps[lag];

	// a pending result blocks the next window.
	assign start = cfg.integrating && !active && !res.valid;
	assign window_done = (win_cnt + 1'b1 >= window_len);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			res.valid <= 1'b0;
		end else begin
			if (res.taken) begin
				res.valid <= 1'b0;
			end
			if (!cfg.integrating) begin
				active <= 1'b0; // the counts of an aborted window are dropped.
			end else if (start) begin
				active <= 1'b1;
			end else if (active && window_done) begin
				active <= 1'b0;
				res.valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			win_cnt <= '0;
			auto_cnt <= '0;
			cross_cnt <= '0;
		end else if (active) begin
			win_cnt <= win_cnt + 1'b1;
			auto_cnt <= auto_cnt + WIN_W'(pulse);
			cross_cnt <= cross_cnt + WIN_W'(pulse & ref_lagged);
		end
	end

	assign res.auto_count = auto_cnt;
	assign res.cross_count = cross_cnt;

endmodule

`default_nettype wire

//--- design/result_collector.sv
`timescale 1ns/100ps
`default_nettype none

module result_collector
	import corr_cfg_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	line_result_if.consumer   res [NUM_LINES],
	output logic              out_req,
	output logic [LINE_W-1:0] out_line,
	output logic [WIN_W-1:0]  out_auto,
	output logic [WIN_W-1:0]  out_cross,
	input  logic              out_ack
);

	typedef enum logic [1:0] {
		SCAN,
		REQ,
		ACK_LOW
	} col_state_e;

	col_state_e           state;
	logic [LINE_W-1:0]    scan_ptr;
	logic [NUM_LINES-1:0] valid_vec;
	logic [WIN_W-1:0]     auto_vec [NUM_LINES];
	logic [WIN_W-1:0]     cross_vec [NUM_LINES];
	logic                 grab;

	for (genvar i = 0; i < NUM_LINES; i++) begin : g_res
		assign valid_vec[i] = res[i].valid;
		assign auto_vec[i] = res[i].auto_count;
		assign cross_vec[i] = res[i].cross_count;
		assign res[i].taken = grab && (scan_ptr == LINE_W'(i));
	end

	// the pointer waits on one line, so results leave in line order.
	assign grab = (state == SCAN) && valid_vec[scan_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= SCAN;
			scan_ptr <= '0;
			out_req <= 1'b0;
			out_line <= '0;
			out_auto <= '0;
			out_cross <= '0;
		end else begin
			case (state)
				SCAN: begin
					if (grab) begin
						out_line <= scan_ptr;
						out_auto <= auto_vec[scan_ptr];
						out_cross <= cross_vec[scan_ptr];
						out_req <= 1'b1;
						state <= REQ;
					end
				end
				REQ: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state <= ACK_LOW;
					end
				end
				ACK_LOW: begin
					if (!out_ack) begin
						scan_ptr <= (scan_ptr == LINE_W'(NUM_LINES - 1)) ? '0 : scan_ptr + 1'b1;
						state <= SCAN;
					end
				end
				default: begin
					state <= SCAN;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/correlator_top.sv
`timescale 1ns/100ps
`default_nettype none

module correlator_top
	import corr_cfg_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cmd_req,
	input  logic [7:0]           cmd_byte,
	input  logic [NUM_LINES-1:0] pulses,
	output logic                 cmd_ack,
	output logic                 out_req,
	output logic [LINE_W-1:0]    out_line,
	output logic [WIN_W-1:0]     out_auto,
	output logic [WIN_W-1:0]     out_cross,
	input  logic                 out_ack
);

	cfg_bus_if     cfg_bus ();
	line_result_if line_res [NUM_LINES] ();

	cmd_decoder u_cmd_decoder (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd_req  (cmd_req),
		.cmd_byte (cmd_byte),
		.cmd_ack  (cmd_ack),
		.cfg      (cfg_bus.decoder)
	);

	// line 0 is the reference for the cross count of every line.
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
		line_correlator u_line (
			.clk       (clk),
			.rst_n     (rst_n),
			.index     (LINE_W'(i)),
			.pulse     (pulses[i]),
			.ref_pulse (pulses[0]),
			.cfg       (cfg_bus.channel),
			.res       (line_res[i].producer)
		);
	end

	result_collector u_collector (
		.clk       (clk),
		.rst_n     (rst_n),
		.res       (line_res),
		.out_req   (out_req),
		.out_line  (out_line),
		.out_auto  (out_auto),
		.out_cross (out_cross),
		.out_ack   (out_ack)
	);

endmodule

`default_nettype wire

//--- test/correlator_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module correlator_assertions
	import corr_cfg_pkg::*;
(
	input logic              clk,
	input logic              rst_n,
	input logic              cmd_req,
	input logic              cmd_ack,
	input logic              out_req,
	input logic              out_ack,
	input logic [LINE_W-1:0] out_line,
	input logic [WIN_W-1:0]  out_auto,
	input logic [WIN_W-1:0]  out_cross
);

	int fail_count = 0;

	idle_in_reset: assert property (@(posedge clk)
		(!rst_n || $rose(rst_n)) |-> (!cmd_ack && !out_req))
		else begin
			fail_count++;
			$error("cmd_ack or out_req high during or right after reset");
		end

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else begin
			fail_count++;
			$error("cmd_ack rose without cmd_req");
		end

	data_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_req && $past(out_req)) |-> $stable({out_line, out_auto, out_cross}))
		else begin
			fail_count++;
			$error("output data changed while out_req was high");
		end

	req_drops: assert property (@(posedge clk) disable iff (!rst_n)
		(out_req && out_ack) |=> !out_req)
		else begin
			fail_count++;
			$error("out_req stayed high after out_ack");
		end

	req_falls_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_req) |-> $past(out_ack))
		else begin
			fail_count++;
			$error("out_req fell without out_ack");
		end

	cross_bound: assert property (@(posedge clk) disable iff (!rst_n)
		out_req |-> (out_cross <= out_auto))
		else begin
			fail_count++;
			$error("out_cross above out_auto");
		end

endmodule

bind correlator_top correlator_assertions u_assertions (.*);

`default_nettype wire

//--- test/tb_correlator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_correlator
	import corr_cmd_pkg::*;
	import corr_cfg_pkg::*;
();

	localparam int TIMEOUT = 4000;
	localparam int HIST_DEPTH = 16384;
	localparam int WIN_OFFSET = 2; // first counted cycle after the capture byte is acknowledged.

	logic                 clk;
	logic                 rst_n;
	logic                 cmd_req;
	logic [7:0]           cmd_byte;
	logic [NUM_LINES-1:0] pulses;
	logic                 cmd_ack;
	logic                 out_req;
	logic [LINE_W-1:0]    out_line;
	logic [WIN_W-1:0]     out_auto;
	logic [WIN_W-1:0]     out_cross;
	logic                 out_ack;

	logic [31:0]          lfsr;
	logic [NUM_LINES-1:0] hist [HIST_DEPTH]; // pulses driven in each cycle.
	int                   cyc;
	int                   ack_cyc;
	logic                 ack_seen;
	logic                 req_seen;
	int                   win_start [NUM_LINES];
	int                   len_m [NUM_LINES];
	int                   lag_m [NUM_LINES];
	int                   next_line;
	int                   results;
	int                   checks;
	int                   errors;

	correlator_top DUT (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic end_run();
		int asrt;
		asrt = DUT.u_assertions.fail_count;
		$display("checks %0d, results %0d, errors %0d, assertion failures %0d",
			checks, results, errors, asrt);
		if (errors == 0 && asrt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[ERROR] %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic reset_model();
		for (int i = 0; i < NUM_LINES; i++) begin
			win_start[i] = -1;
			len_m[i] = WINDOW_RESET;
			lag_m[i] = LAG_RESET;
		end
	endtask

	// expected counts come from the pulse history over the line's own window.
	task automatic check_result(input int m);
		int idx;
		int exp_auto;
		int exp_cross;
		idx = next_line;
		exp_auto = 0;
		exp_cross = 0;
		check_value("out_line", out_line, idx);
		checks++;
		assert (win_start[idx] >= 0) else begin
			errors++;
			$display("a result from line %0d arrived while no window was running", idx);
		end
		if (win_start[idx] >= 0) begin
			for (int c = win_start[idx]; c < win_start[idx] + len_m[idx]; c++) begin
				exp_auto += hist[c][idx];
				exp_cross += hist[c][idx] & hist[c - lag_m[idx]][0];
			end
			check_value("out_auto", out_auto, exp_auto);
			check_value("out_cross", out_cross, exp_cross);
			check_value("out_auto within window", out_auto <= len_m[idx], 1);
		end
		win_start[idx] = m + 1; // taken with out_req, so the next window follows at once.
		next_line = (idx + 1) % NUM_LINES;
		results++;
	endtask

	task automatic wait_for(input logic on_req, input logic level, input string what);
		int n;
		n = 0;
		while ((on_req ? out_req : cmd_ack) !== level && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if ((on_req ? out_req : cmd_ack) !== level) begin
			errors++;
			$display("timed out waiting for %s", what);
			end_run();
		end
	endtask

	task automatic send_cmd(input logic [7:0] b);
		cmd_byte = b;
		cmd_req = 1'b1;
		@(negedge clk);
		wait_for(1'b0, 1'b1, "cmd_ack to rise");
		cmd_req = 1'b0;
		wait_for(1'b0, 1'b0, "cmd_ack to fall");
	endtask

	task automatic load_word(input cmd_opcode_e op, input int nibbles, input logic [15:0] value);
		send_cmd({4'(nibbles), op});
		for (int i = 0; i < nibbles; i++) begin
			send_cmd({value[i*4 +: 4], op});
		end
		send_cmd({4'd0, op}); // one byte past the length closes the load.
	endtask

	task automatic start_capture();
		send_cmd({4'd1, ENABLE_CAPTURE});
		for (int i = 0; i < NUM_LINES; i++) begin
			win_start[i] = ack_cyc + WIN_OFFSET;
		end
	endtask

	task automatic drain(input int n, input int hold);
		repeat (n) begin
			wait_for(1'b1, 1'b1, "out_req to rise");
			repeat (hold) @(negedge clk);
			out_ack = 1'b1;
			wait_for(1'b1, 1'b0, "out_req to fall");
			out_ack = 1'b0;
		end
	endtask

	// one full round of results, then capture stops while every window is young.
	task automatic run_round();
		start_capture();
		drain(NUM_LINES, 0);
		send_cmd({ENABLE_CAPTURE, CLEAR});
		for (int i = 0; i < NUM_LINES; i++) begin
			win_start[i] = -1; // the restarted windows are aborted.
		end
	endtask

	always @(negedge clk) begin
		if (cmd_ack && !ack_seen) begin
			ack_cyc = cyc;
		end
		if (out_req && !req_seen) begin
			check_result(cyc);
		end
		ack_seen = cmd_ack;
		req_seen = out_req;
		for (int i = 0; i < NUM_LINES; i++) begin
			pulses[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		hist[cyc] = pulses;
		cyc++;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		cmd_req = 1'b0;
		cmd_byte = '0;
		pulses = '0;
		out_ack = 1'b0;
		lfsr = 32'h937f_1620;
		cyc = 0;
		ack_cyc = 0;
		ack_seen = 1'b0;
		req_seen = 1'b0;
		next_line = 0;
		results = 0;
		checks = 0;
		errors = 0;
		reset_model();
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("cmd_ack", cmd_ack, 0);
		check_value("out_req", out_req, 0);
		run_round(); // default settings on every line.
		load_word(SET_LINE, 1, 2);
		send_cmd({4'(FIELD_LAG), SELECT_FIELD});
		load_word(SET_VALUE, 1, 3);
		lag_m[2] = 3;
		run_round();
		load_word(SET_LINE, 1, 1);
		send_cmd({4'(FIELD_WINDOW), SELECT_FIELD});
		load_word(SET_VALUE, 4, 16'h0040);
		len_m[1] = 64;
		run_round();
		send_cmd({SET_VALUE, CLEAR});
		reset_model();
		start_capture();
		drain(1, 2500); // held lines keep their results and start nothing new.
		drain(2 * NUM_LINES - 1, 0);
		end_run();
	end

endmodule

`default_nettype wire

//--- files.f
design/corr_cmd_pkg.sv
design/corr_cfg_pkg.sv
design/cfg_bus_if.sv
design/line_result_if.sv
design/cmd_decoder.sv
design/line_correlator.sv
design/result_collector.sv
design/correlator_top.sv
test/correlator_assertions.sv
test/tb_correlator.sv

//--- Bender.yml
package:
  name: pulse_correlator

sources:
  - files:
      - design/corr_cmd_pkg.sv
      - design/corr_cfg_pkg.sv
      - design/cfg_bus_if.sv
      - design/line_result_if.sv
      - design/cmd_decoder.sv
      - design/line_correlator.sv
      - design/result_collector.sv
      - design/correlator_top.sv
  - target: test
    files:
      - test/correlator_assertions.sv
      - test/tb_correlator.sv
